// ==== tb/dprio_stimulus.txt ====
# C new old chk | W addr be data | R addr data bsel | O grp idx data
# A addr idx accept | M mdio_dis | E csr_en   (all fields hex)
C 0120 0000 0
C 0120 0120 1
W 120 3 a5c3
W 121 1 1234
W 124 2 beef
W 129 1 77aa
O 0 1 0034
O 1 0 be00
O 2 1 00aa
R 120 a5c3 1
W 121 2 5600
R 121 5634 1
W 122 3 ffff
R 122 0000 1
R 12f 0000 0
A 12c 0 1
A 12e 2 1
M 1
W 120 3 0000
M 0
R 120 a5c3 1
C 2120 0120 1
W 124 3 0000
R 124 0000 0
E 0
O 0 0 0000
E 1
C 4120 2120 1
R 124 be00 1
W 200 3 1111
R 200 0000 0
R 120 1111 1
O 0 0 1111
C 8120 4120 1
A 12c 0 0
C 0120 8120 1
A 12c 0 1

// ==== all.f ====
+incdir+src
+incdir+tb
src/dprio_cfg_pkg.sv
src/dprio_bus_pkg.sv
src/csr_shift_chain.sv
src/dprio_addr_decode.sv
src/dprio_reg_file.sv
src/dprio_ctrl_stat_top.sv
tb/tb_dprio_ctrl_stat.sv

// ==== Bender.yml ====
package:
  name: dprio_ctrl_stat

sources:
  - include_dirs:
      - src
    files:
      - src/dprio_cfg_pkg.sv
      - src/dprio_bus_pkg.sv
      - src/csr_shift_chain.sv
      - src/dprio_addr_decode.sv
      - src/dprio_reg_file.sv
      - src/dprio_ctrl_stat_top.sv
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/tb_dprio_ctrl_stat.sv

// ==== tb/dprio_tb_checks.svh ====
`ifndef DPRIO_TB_CHECKS_SVH
`define DPRIO_TB_CHECKS_SVH

// ****************************************************************************
// Compare tasks for each result type
// ****************************************************************************
task automatic check_data(input logic [`DPRIO_DATA_WIDTH-1:0] act,
                          input logic [`DPRIO_DATA_WIDTH-1:0] exp,
                          input string                        what);
  if (act !== exp)
  begin
    mismatch_cnt++;
    $display("CHECK FAILED %0t: %s got %h expected %h", $time, what, act, exp);
  end
endtask

task automatic check_csr(input extra_csr_t act, input extra_csr_t exp, input string what);
  if (act !== exp)
  begin
    mismatch_cnt++;
    $display("CHECK FAILED %0t: %s got %h expected %h", $time, what, act, exp);
  end
endtask

task automatic check_bit(input logic act, input logic exp, input string what);
  if (act !== exp)
  begin
    mismatch_cnt++;
    $display("CHECK FAILED %0t: %s got %b expected %b", $time, what, act, exp);
  end
endtask

// ****************************************************************************
// Bounded waits on falling edges
// ****************************************************************************
task automatic wait_block_select(input int limit, output logic found, output int cycles);
  cycles = 0;
  while ((block_select !== 1'b1) && (cycles < limit))
  begin
    @(negedge dprio_clk);
    cycles++;
  end
  found = (block_select === 1'b1);              // Low when the window closed empty
endtask

task automatic wait_write_en_low(input int idx, input int limit, output logic ok);
  int cycles;
  cycles = 0;
  while ((write_en[idx] !== 1'b0) && (cycles < limit))
  begin
    @(negedge dprio_clk);
    cycles++;
  end
  ok = (write_en[idx] === 1'b0);
  if (!ok)
  begin
    other_cnt++;
    $display("Timeout: write_en[%0d] still high after %0d cycles, no ack taken", idx, limit);
  end
endtask

// Ack is ignored, so the request must stay up for the whole window
task automatic hold_write_en(input int idx, input int cycles);
  for (int c = 0; c < cycles; c++)
  begin
    @(negedge dprio_clk);
    if (write_en[idx] !== 1'b1)
    begin
      check_bit(write_en[idx], 1'b1, $sformatf("write_en[%0d] under isolation", idx));
      break;
    end
  end
endtask

`endif

// ==== tb/tb_dprio_ctrl_stat.sv ====
`include "dprio_params.svh"

module tb_dprio_ctrl_stat;

  import dprio_bus_pkg::*;
  import dprio_cfg_pkg::*;

  localparam int W         = `DPRIO_DATA_WIDTH;
  localparam int CSR_W     = `DPRIO_EXTRA_CSR_WIDTH;
  localparam int NUM_STAT  = `DPRIO_NUM_STATUS;
  localparam int RD_WAIT   = 2;   // Negedges from strobe release to data
  localparam int RD_WINDOW = 4;   // Look-out for block_select
  localparam int ACK_LIMIT = 40;  // Longest status exchange
  localparam int HOLD_CYC  = 20;  // Well past the longest ack delay

  logic                            csr_clk;
  logic                            csr_in;
  logic                            csr_en;
  logic                            csr_out;
  extra_csr_t                      extra_csr;
  logic                            dprio_clk;
  logic                            rst_n;
  bus_req_t                        bus_req;
  logic                            mdio_dis;
  logic [W-1:0]                    readdata;
  logic                            block_select;
  logic [W*NUM_STAT-1:0]           user_datain;
  logic [NUM_STAT-1:0]             write_en_ack;
  logic [NUM_STAT-1:0]             write_en;
  logic [W*`DPRIO_NUM_TX_CTRL-1:0] tx_user_dataout;
  logic [W*`DPRIO_NUM_RX_CTRL-1:0] rx_user_dataout;
  logic [W*`DPRIO_NUM_CM_CTRL-1:0] cm_user_dataout;
  int                              mismatch_cnt;
  int                              other_cnt;   // Timeouts and stimulus errors
  logic [W-1:0]                    stat_exp [NUM_STAT];  // user_datain at last ack
  int                              ack_cnt [NUM_STAT];   // -1 while idle

  `include "dprio_tb_checks.svh"

  dprio_ctrl_stat_top i_dut (.*);

  always #10 dprio_clk = ~dprio_clk;

  // User side of the status exchange, ack after a random delay
  task automatic user_model();
    forever
    begin
      @(negedge dprio_clk);
      for (int i = 0; i < NUM_STAT; i++)
      begin
        if (write_en_ack[i])
        begin
          write_en_ack[i]       = 1'b0;
          user_datain[i*W +: W] = W'($urandom);      // Moves on after capture
          ack_cnt[i]            = -1;
        end
        else if (write_en[i])
        begin
          if (ack_cnt[i] < 0)
            ack_cnt[i] = $urandom % 6;
          else if (ack_cnt[i] == 0)
          begin
            user_datain[i*W +: W] = W'($urandom);
            stat_exp[i]           = user_datain[i*W +: W];
            write_en_ack[i]       = 1'b1;
          end
          else
            ack_cnt[i]--;
        end
      end
    end
  endtask

  // Old word leaves on csr_out while the new one enters, MSB first
  task automatic shift_csr(input logic [CSR_W-1:0] new_word, input logic [CSR_W-1:0] old_word,
                           input logic check_old);
    logic [CSR_W-1:0] seen;
    csr_en = 1'b0;                                   // Bus off while loading
    for (int k = CSR_W-1; k >= 0; k--)
    begin
      seen[k] = csr_out;
      csr_in  = new_word[k];
      #5 csr_clk = 1'b1;
      #5 csr_clk = 1'b0;
      @(negedge dprio_clk);
    end
    if (check_old)
      check_data(seen, old_word, "csr_out stream");
    csr_en = 1'b1;
    @(negedge dprio_clk);
    check_csr(extra_csr, extra_csr_t'(new_word), "extra_csr after load");
  endtask

  task automatic bus_write(input logic [`DPRIO_ADDR_WIDTH-1:0] addr, input logic [1:0] be,
                           input logic [W-1:0] data);
    bus_req         = '0;
    bus_req.write   = 1'b1;
    bus_req.byte_en = be;
    bus_req.addr    = addr;
    bus_req.wdata   = data;
    @(negedge dprio_clk);
    bus_req = '0;
    repeat (2) @(negedge dprio_clk);                 // Landed at N+2
  endtask

  task automatic bus_read(input logic [`DPRIO_ADDR_WIDTH-1:0] addr, output logic found,
                          output logic [W-1:0] data);
    int lat;
    bus_req      = '0;
    bus_req.read = 1'b1;
    bus_req.addr = addr;
    @(negedge dprio_clk);
    bus_req = '0;
    wait_block_select(RD_WINDOW, found, lat);
    data = readdata;
    if (found)
      check_bit(lat == RD_WAIT, 1'b1, $sformatf("read latency at %h", addr));
  endtask

  task automatic check_read(input logic [`DPRIO_ADDR_WIDTH-1:0] addr, input logic [W-1:0] exp,
                            input logic exp_sel);
    logic         found;
    logic [W-1:0] data;
    bus_read(addr, found, data);
    check_bit(found, exp_sel, $sformatf("block_select for read %h", addr));
    if (found)
      check_data(data, exp, $sformatf("readdata at %h", addr));
  endtask

  task automatic check_user_out(input int grp, input int idx, input logic [W-1:0] exp);
    logic [W-1:0] act;
    case (grp)
      0: act = tx_user_dataout[idx*W +: W];
      1: act = rx_user_dataout[idx*W +: W];
      default: act = cm_user_dataout[idx*W +: W];
    endcase
    check_data(act, exp, $sformatf("user output grp %0d idx %0d", grp, idx));
  endtask

  task automatic status_exchange(input logic [`DPRIO_ADDR_WIDTH-1:0] addr, input int idx,
                                 input logic accept);
    logic         ok;
    logic         found;
    logic [W-1:0] data;
    bus_write(addr, 2'b11, '0);
    check_bit(write_en[idx], 1'b1, $sformatf("write_en[%0d] after status write", idx));
    if (!accept)
      hold_write_en(idx, HOLD_CYC);
    else
    begin
      wait_write_en_low(idx, ACK_LIMIT, ok);
      if (ok)
      begin
        bus_read(addr, found, data);
        check_bit(found, 1'b1, "block_select for status read");
        check_data(data, stat_exp[idx], $sformatf("status %0d", idx));
      end
    end
  endtask

  // ****************************************************************************
  // Reset, then one stimulus command per line
  // ****************************************************************************
  initial
  begin
    int          fd;
    int          n;
    int          nf;
    logic [63:0] tok;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [1023:0] rest;
    dprio_clk    = 1'b0;
    csr_clk      = 1'b0;
    csr_in       = 1'b0;
    csr_en       = 1'b0;
    rst_n        = 1'b0;
    bus_req      = '0;
    mdio_dis     = 1'b0;
    user_datain  = '0;
    write_en_ack = '0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    for (int i = 0; i < NUM_STAT; i++)
    begin
      stat_exp[i] = '0;
      ack_cnt[i]  = -1;
    end
    void'($urandom(32'ha2ec_de29));
    fork
      user_model();
    join_none
    repeat (16) @(negedge dprio_clk);
    rst_n = 1'b1;
    fd = $fopen("tb/dprio_stimulus.txt", "r");
    if (fd == 0)
    begin
      other_cnt++;
      $display("Could not open tb/dprio_stimulus.txt");
    end
    else
    begin
      while ($fscanf(fd, "%s", tok) == 1)
      begin
        if (tok == "#")
        begin
          void'($fgets(rest, fd));                   // Column notes
          continue;
        end
        nf = ((tok == "M") || (tok == "E")) ? 1 : 3;
        if (nf == 1)
          n = $fscanf(fd, "%h", f1);
        else
          n = $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (n != nf)
        begin
          other_cnt++;
          $display("Stimulus line for command %0s has missing fields", tok);
          break;
        end
        case (tok)
          "C": shift_csr(f1[CSR_W-1:0], f2[CSR_W-1:0], f3[0]);
          "W": bus_write(f1[`DPRIO_ADDR_WIDTH-1:0], f2[1:0], f3[W-1:0]);
          "R": check_read(f1[`DPRIO_ADDR_WIDTH-1:0], f2[W-1:0], f3[0]);
          "O": check_user_out(f1, f2, f3[W-1:0]);
          "A": status_exchange(f1[`DPRIO_ADDR_WIDTH-1:0], f2, f3[0]);
          "M":
          begin
            mdio_dis = f1[0];
            @(negedge dprio_clk);
          end
          "E":
          begin
            csr_en = f1[0];                          // Gates the user outputs
            @(negedge dprio_clk);
          end
          default:
          begin
            other_cnt++;
            $display("Unknown stimulus command %0s", tok);
          end
        endcase
      end
      $fclose(fd);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if ((mismatch_cnt == 0) && (other_cnt == 0))
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== src/dprio_ctrl_stat_top.sv ====
`include "dprio_params.svh"

module dprio_ctrl_stat_top (
  // CSR chain
  input  logic                                            csr_clk,
  input  logic                                            csr_in,
  input  logic                                            csr_en,
  output logic                                            csr_out,
  output dprio_cfg_pkg::extra_csr_t                       extra_csr,
  // DPRIO bus
  input  logic                                            dprio_clk,
  input  logic                                            rst_n,
  input  dprio_bus_pkg::bus_req_t                         bus_req,
  input  logic                                            mdio_dis,   // 1 ignores bus
  output logic [`DPRIO_DATA_WIDTH-1:0]                    readdata,
  output logic                                            block_select,
  // User logic
  input  logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_STATUS-1:0]  user_datain,
  input  logic [`DPRIO_NUM_STATUS-1:0]                    write_en_ack,
  output logic [`DPRIO_NUM_STATUS-1:0]                    write_en,
  output logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_TX_CTRL-1:0] tx_user_dataout,
  output logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_RX_CTRL-1:0] rx_user_dataout,
  output logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_CM_CTRL-1:0] cm_user_dataout
);

  import dprio_bus_pkg::*;

  reg_op_t reg_op;  // Decoder to register file

  csr_shift_chain i_chain (
    .csr_clk   (csr_clk),
    .csr_in    (csr_in),
    .csr_en    (csr_en),
    .csr_out   (csr_out),
    .extra_csr (extra_csr)
  );

  dprio_addr_decode i_decode (
    .dprio_clk (dprio_clk),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .extra_csr (extra_csr),
    .mdio_dis  (mdio_dis),
    .csr_en    (csr_en),
    .reg_op    (reg_op)
  );

  dprio_reg_file i_reg_file (
    .dprio_clk       (dprio_clk),
    .rst_n           (rst_n),
    .reg_op          (reg_op),
    .extra_csr       (extra_csr),
    .csr_en          (csr_en),
    .user_datain     (user_datain),
    .write_en_ack    (write_en_ack),
    .write_en        (write_en),
    .readdata        (readdata),
    .block_select    (block_select),
    .tx_user_dataout (tx_user_dataout),
    .rx_user_dataout (rx_user_dataout),
    .cm_user_dataout (cm_user_dataout)
  );

endmodule

// ==== src/dprio_reg_file.sv ====
`include "dprio_params.svh"

module dprio_reg_file (
  input  logic                                            dprio_clk,
  input  logic                                            rst_n,
  input  dprio_bus_pkg::reg_op_t                          reg_op,
  input  dprio_cfg_pkg::extra_csr_t                       extra_csr,
  input  logic                                            csr_en,
  input  logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_STATUS-1:0]  user_datain,
  input  logic [`DPRIO_NUM_STATUS-1:0]                    write_en_ack,
  output logic [`DPRIO_NUM_STATUS-1:0]                    write_en,
  output logic [`DPRIO_DATA_WIDTH-1:0]                    readdata,
  output logic                                            block_select,
  output logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_TX_CTRL-1:0] tx_user_dataout,
  output logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_RX_CTRL-1:0] rx_user_dataout,
  output logic [`DPRIO_DATA_WIDTH*`DPRIO_NUM_CM_CTRL-1:0] cm_user_dataout
);

  import dprio_bus_pkg::*;

  localparam int W        = `DPRIO_DATA_WIDTH;
  localparam int NUM_TX   = `DPRIO_NUM_TX_CTRL;
  localparam int NUM_RX   = `DPRIO_NUM_RX_CTRL;
  localparam int NUM_CM   = `DPRIO_NUM_CM_CTRL;
  localparam int NUM_CTRL = NUM_TX + NUM_RX + NUM_CM;
  localparam int NUM_STAT = `DPRIO_NUM_STATUS;
  localparam int SLOT_W   = $clog2(NUM_CTRL);

  reg_op_t                   op_q;                   // Op aligned to N+2
  logic [W-1:0]              ctrl_q [NUM_CTRL];      // TX, then RX, then CM
  logic [W-1:0]              stat_q [NUM_STAT];
  logic [W*NUM_CTRL-1:0]     ctrl_flat;              // Gated user view
  logic [SLOT_W-1:0]         ctrl_slot;
  logic                      ctrl_hit;
  logic [W-1:0]              rd_data;
  logic [W*NUM_STAT-1:0]     datain_int;             // After power isolation
  logic [NUM_STAT-1:0]       ack_int;

  // Isolated user side looks idle
  assign datain_int = extra_csr.power_iso ? '0 : user_datain;
  assign ack_int    = extra_csr.power_iso ? '0 : write_en_ack;

  always_ff @(posedge dprio_clk or negedge rst_n)
  begin
    if (!rst_n)
      op_q <= '0;
    else
      op_q <= reg_op;
  end

  // Flat control slot for the addressed group
  always_comb
  begin
    ctrl_hit  = 1'b1;
    ctrl_slot = '0;
    case (op_q.group)
      GRP_TX: ctrl_slot = SLOT_W'(op_q.index);
      GRP_RX: ctrl_slot = SLOT_W'(NUM_TX + op_q.index);
      GRP_CM: ctrl_slot = SLOT_W'(NUM_TX + NUM_RX + op_q.index);
      default: ctrl_hit = 1'b0;                      // Status, holes
    endcase
  end

  // ************************************************************************
  // Control registers with byte masking
  // ************************************************************************
  always_ff @(posedge dprio_clk or negedge rst_n)
  begin
    if (!rst_n)
      ctrl_q <= '{default: '0};
    else if ((op_q.op == OP_WRITE) && ctrl_hit)
    begin
      for (int b = 0; b < `DPRIO_BYTE_EN_WIDTH; b++)
      begin
        if (op_q.byte_en[b])
          ctrl_q[ctrl_slot][b*8 +: 8] <= op_q.wdata[b*8 +: 8];
      end
    end
  end

  // ************************************************************************
  // Status refresh via write_en / write_en_ack
  // ************************************************************************
  always_ff @(posedge dprio_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      write_en <= '0;
      stat_q   <= '{default: '0};
    end
    else
    begin
      for (int i = 0; i < NUM_STAT; i++)
      begin
        if (write_en[i] && ack_int[i])
        begin
          stat_q[i]   <= datain_int[i*W +: W];     // Capture at ack edge
          write_en[i] <= 1'b0;
        end
        if ((op_q.op == OP_WRITE) && (op_q.group == GRP_STAT) && (op_q.index == i))
          write_en[i] <= 1'b1;                     // New request wins
      end
    end
  end

  // Read-back, holes and misses read zero
  always_comb
  begin
    rd_data = '0;
    if (ctrl_hit)
      rd_data = ctrl_q[ctrl_slot];
    else if (op_q.group == GRP_STAT)
      rd_data = stat_q[op_q.index];
  end

  always_ff @(posedge dprio_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      readdata     <= '0;
      block_select <= 1'b0;
    end
    else
    begin
      block_select <= (op_q.op == OP_READ);        // One-cycle pulse
      readdata     <= (op_q.op == OP_READ) ? rd_data : '0;
    end
  end

  // User outputs held at zero while the chain loads
  for (genvar r = 0; r < NUM_CTRL; r++)
  begin : g_ctrl_out
    assign ctrl_flat[r*W +: W] = csr_en ? ctrl_q[r] : '0;
  end

  assign tx_user_dataout = ctrl_flat[0 +: W*NUM_TX];
  assign rx_user_dataout = ctrl_flat[W*NUM_TX +: W*NUM_RX];
  assign cm_user_dataout = ctrl_flat[W*(NUM_TX+NUM_RX) +: W*NUM_CM];

  // Request must stay up until the user side accepts it
  a_wen_hold: assert property (@(posedge dprio_clk) disable iff (!rst_n)
    (($past(write_en) & ~write_en & ~$past(ack_int)) == '0))
    else $error("write_en dropped without write_en_ack");

endmodule

// ==== src/dprio_addr_decode.sv ====
`include "dprio_params.svh"

module dprio_addr_decode (
  input  logic                       dprio_clk,
  input  logic                       rst_n,
  input  dprio_bus_pkg::bus_req_t    bus_req,    // Raw bus strobes
  input  dprio_cfg_pkg::extra_csr_t  extra_csr,  // Base, broadcast, force
  input  logic                       mdio_dis,   // Bus disabled
  input  logic                       csr_en,     // Low while chain loads
  output dprio_bus_pkg::reg_op_t     reg_op      // Registered op strobe
);

  import dprio_bus_pkg::*;
  import dprio_cfg_pkg::*;

  localparam int OFS_W = $clog2(`DPRIO_MAP_SPAN);
  localparam int IDX_W = `DPRIO_IDX_WIDTH;

  logic             bus_sel;   // Bus owns the register file
  base_addr_t       ofs;       // Address relative to base
  logic             in_range;  // Offset inside this block
  logic [OFS_W-1:0] ofs_lo;    // Low offset bits pick the register
  reg_group_e       grp;
  logic [IDX_W-1:0] idx;
  reg_op_e          op_d;

  // ************************************************************************
  // Interface selection and relocation
  // ************************************************************************
  assign bus_sel  = csr_en & ~mdio_dis & ~extra_csr.force_sel;
  assign ofs      = bus_req.addr - extra_csr.base_addr;       // Wraps on miss
  assign in_range = (ofs < base_addr_t'(`DPRIO_MAP_SPAN));
  assign ofs_lo   = ofs[OFS_W-1:0];

  // Group and index from the low offset bits
  always_comb
  begin
    grp = GRP_MISS;
    idx = '0;
    if (ofs_lo < `DPRIO_OFS_TX_RSVD)
    begin
      grp = GRP_TX;
      idx = IDX_W'(ofs_lo);
    end
    else if (ofs_lo < `DPRIO_OFS_RX)
      grp = GRP_RSVD;                                         // TX hole
    else if (ofs_lo < `DPRIO_OFS_RX_RSVD)
    begin
      grp = GRP_RX;
      idx = IDX_W'(ofs_lo - `DPRIO_OFS_RX);
    end
    else if (ofs_lo < `DPRIO_OFS_CM)
      grp = GRP_RSVD;                                         // RX hole
    else if (ofs_lo < `DPRIO_OFS_CM_RSVD)
    begin
      grp = GRP_CM;
      idx = IDX_W'(ofs_lo - `DPRIO_OFS_CM);
    end
    else if (ofs_lo < `DPRIO_OFS_STAT)
      grp = GRP_RSVD;                                         // CM hole
    else if (ofs_lo < `DPRIO_MAP_SPAN)
    begin
      grp = GRP_STAT;
      idx = IDX_W'(ofs_lo - `DPRIO_OFS_STAT);
    end
  end

  // Broadcast widens writes only; reads need a real base match
  always_comb
  begin
    op_d = OP_IDLE;
    if (bus_sel && bus_req.write && (in_range || extra_csr.broadcast_en)
        && (grp != GRP_MISS))
      op_d = OP_WRITE;
    else if (bus_sel && bus_req.read && in_range)
      op_d = OP_READ;
  end

  // ************************************************************************
  // Request register, one op per accepted strobe
  // ************************************************************************
  always_ff @(posedge dprio_clk or negedge rst_n)
  begin
    if (!rst_n)
      reg_op <= '0;                                           // OP_IDLE
    else
    begin
      reg_op.op      <= op_d;
      reg_op.group   <= grp;
      reg_op.index   <= idx;
      reg_op.byte_en <= bus_req.byte_en;
      reg_op.wdata   <= bus_req.wdata;
    end
  end

  // The master never issues both strobes in one cycle
  a_rw_excl: assert property (@(posedge dprio_clk) disable iff (!rst_n)
    !(bus_req.read && bus_req.write))
    else $error("read and write asserted together");

endmodule

// ==== src/csr_shift_chain.sv ====
`include "dprio_params.svh"

module csr_shift_chain (
  input  logic                       csr_clk,    // CSR shift clock
  input  logic                       csr_in,     // Serial in, MSB first
  input  logic                       csr_en,     // Low shifts, high holds
  output logic                       csr_out,    // Serial out
  output dprio_cfg_pkg::extra_csr_t  extra_csr   // Parallel view of the word
);

  import dprio_cfg_pkg::*;

  localparam int W = `DPRIO_EXTRA_CSR_WIDTH;

  logic [W-1:0] chain_q;  // Quasi-static after csr_en rises

  // ************************************************************************
  // Shift chain holding the extra CSR word
  // ************************************************************************
  always_ff @(posedge csr_clk)
  begin
    if (!csr_en)
    begin
      chain_q <= {chain_q[W-2:0], csr_in};  // New bit enters at 0
    end
  end

  assign csr_out   = chain_q[W-1];          // Bit shifted in W edges ago
  assign extra_csr = extra_csr_t'(chain_q);

  // A glitchy enable would corrupt the word while the bus relies on it
  a_csr_en_known: assert property (@(posedge csr_clk) !$isunknown(csr_en))
    else $error("csr_en unknown on csr_clk edge");

endmodule

// ==== src/dprio_bus_pkg.sv ====
`include "dprio_params.svh"

package dprio_bus_pkg;

  // ************************************************************************
  // Bus request as driven by the central DPRIO master
  // ************************************************************************
  typedef struct packed {
    logic                            write;    // Write strobe
    logic                            read;     // Read strobe
    logic [`DPRIO_BYTE_EN_WIDTH-1:0] byte_en;  // Per-byte write enable
    logic [`DPRIO_ADDR_WIDTH-1:0]    addr;     // Absolute address
    logic [`DPRIO_DATA_WIDTH-1:0]    wdata;    // Write data
  } bus_req_t;

  // Region of the map an offset falls in
  typedef enum logic [2:0] {
    GRP_TX,    // TX control
    GRP_RX,    // RX control
    GRP_CM,    // Common control
    GRP_STAT,  // Status
    GRP_RSVD,  // Reserved hole
    GRP_MISS   // Outside the map
  } reg_group_e;

  typedef enum logic [1:0] {
    OP_IDLE,
    OP_WRITE,
    OP_READ
  } reg_op_e;

  // Decoded operation towards the register file
  typedef struct packed {
    reg_op_e                         op;       // One-cycle strobe
    reg_group_e                      group;
    logic [`DPRIO_IDX_WIDTH-1:0]     index;    // Register inside group
    logic [`DPRIO_BYTE_EN_WIDTH-1:0] byte_en;
    logic [`DPRIO_DATA_WIDTH-1:0]    wdata;
  } reg_op_t;

endpackage

// ==== src/dprio_cfg_pkg.sv ====
`include "dprio_params.svh"

package dprio_cfg_pkg;

  // Relocatable base of the register map
  typedef logic [`DPRIO_ADDR_WIDTH-1:0] base_addr_t;

  // ************************************************************************
  // Extra CSR word, MSB first as shifted in
  // ************************************************************************
  typedef struct packed {
    logic       power_iso;     // Bit 15 isolate user status inputs
    logic       broadcast_en;  // Bit 14 accept writes at any base
    logic       force_sel;     // Bit 13 force bus off
    logic [1:0] rsvd;          // Bits 12:11 unused
    base_addr_t base_addr;     // Bits 10:0
  } extra_csr_t;

endpackage

// ==== src/dprio_params.svh ====
`ifndef DPRIO_PARAMS_SVH
`define DPRIO_PARAMS_SVH

// ************************************************************************
// Bus and register widths
// ************************************************************************
`define DPRIO_DATA_WIDTH       16                     // Register and bus data
`define DPRIO_ADDR_WIDTH       11                     // DPRIO address
`define DPRIO_BYTE_EN_WIDTH    (`DPRIO_DATA_WIDTH/8)  // One enable per byte
`define DPRIO_IDX_WIDTH        2                      // Index inside a group
`define DPRIO_EXTRA_CSR_WIDTH  16                     // Serial chain length

// ************************************************************************
// Register counts
// ************************************************************************
`define DPRIO_NUM_TX_CTRL      2                      // TX control regs
`define DPRIO_NUM_RX_CTRL      2                      // RX control regs
`define DPRIO_NUM_CM_CTRL      2                      // Common control regs
`define DPRIO_NUM_RSVD         2                      // Hole after each ctrl group
`define DPRIO_NUM_STATUS       3                      // Status regs, last group

// Offsets from base_addr, in map order
`define DPRIO_OFS_TX_RSVD      (`DPRIO_NUM_TX_CTRL)
`define DPRIO_OFS_RX           (`DPRIO_OFS_TX_RSVD + `DPRIO_NUM_RSVD)
`define DPRIO_OFS_RX_RSVD      (`DPRIO_OFS_RX + `DPRIO_NUM_RX_CTRL)
`define DPRIO_OFS_CM           (`DPRIO_OFS_RX_RSVD + `DPRIO_NUM_RSVD)
`define DPRIO_OFS_CM_RSVD      (`DPRIO_OFS_CM + `DPRIO_NUM_CM_CTRL)
`define DPRIO_OFS_STAT         (`DPRIO_OFS_CM_RSVD + `DPRIO_NUM_RSVD)
`define DPRIO_MAP_SPAN         (`DPRIO_OFS_STAT + `DPRIO_NUM_STATUS)

`endif
